//--- design/dds_spi_pkg.sv
package dds_spi_pkg;

	////////////////////////////////////////////////////////////
	// instruction word fields
	////////////////////////////////////////////////////////////

	// the first bit sent selects write (0) or read (1)
	localparam logic INSTR_WRITE = 1'b0;	// only writes are issued

	// length code follows the r/w bit
	localparam logic [1:0] LEN_CODE_64 = 2'd3;	// streaming, 48-bit ftw
	localparam logic [1:0] LEN_CODE_32 = 2'd1;	// two data bytes

	////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////

	// addresses point at the msb of each register,
	// and the chip auto-decrements while streaming
	localparam logic [12:0] ADDR_FTW   = 13'h01AB;	// frequency tuning word
	localparam logic [12:0] ADDR_PHASE = 13'h01AD;	// phase offset word
	localparam logic [12:0] ADDR_AMP   = 13'h040C;	// dac full-scale current

	////////////////////////////////////////////////////////////
	// instruction lengths
	////////////////////////////////////////////////////////////

	localparam int unsigned FREQ_INSTR_BITS  = 64;	// 16 header + 48 data
	localparam int unsigned SHORT_INSTR_BITS = 32;	// 16 header + 16 data

endpackage

//--- design/update_req_pkg.sv
package update_req_pkg;

	// which dds register a request targets
	typedef enum logic [1:0] {
		KIND_FREQ  = 2'd0,	// 48-bit tuning word
		KIND_PHASE = 2'd1,	// 14-bit phase
		KIND_AMP   = 2'd2	// 10-bit amplitude
	} req_kind_e;

	// phase and amplitude travel in the low bits of the payload.
	// amplitude only uses value[9:0], the rest stays zero
	typedef struct packed {
		logic [33:0] pad;	// always zero
		logic [13:0] value;	// phase, or amplitude in low 10 bits
	} short_reg_s;

	// one 48-bit payload word, read as ftw or as short register
	typedef union packed {
		logic [47:0] ftw;	// frequency tuning word view
		short_reg_s  short;	// phase / amplitude view
	} update_payload_u;

	// stored width of one request
	localparam int unsigned REQ_BITS = $bits(req_kind_e) + $bits(update_payload_u);

endpackage

//--- design/tuning_change_filter.sv
module tuning_change_filter
	import update_req_pkg::*;
(
	input  logic            clk_in,
	input  logic            reset_in,
	input  logic [47:0]     freq,		// new tuning word
	input  logic [13:0]     phase,		// new phase
	input  logic [9:0]      amp,		// new amplitude
	input  logic            freq_dv,	// single-cycle strobes
	input  logic            phase_dv,
	input  logic            amp_dv,
	output logic            push,		// one request per cycle at most
	output req_kind_e       push_kind,
	output update_payload_u push_payload
);

	logic [2:0]      strb;			// strobes indexed by kind
	update_payload_u in_pl [3];		// incoming values as payloads
	update_payload_u pend_pl [3];		// waiting values
	update_payload_u last_pl [3];		// last value pushed per kind
	logic [2:0]      pend_q;		// waiting flags
	logic [2:0]      last_ok;		// last_pl holds a real value
	logic [2:0]      live;			// waiting and actually changed
	logic [2:0]      issue;			// one-hot, kind pushed this cycle
	req_kind_e       sel;			// kind pushed this cycle

	assign strb = {amp_dv, phase_dv, freq_dv};

	always_comb begin
		in_pl[KIND_FREQ]             = '0;
		in_pl[KIND_FREQ].ftw         = freq;
		in_pl[KIND_PHASE]            = '0;
		in_pl[KIND_PHASE].short.value = phase;
		in_pl[KIND_AMP]              = '0;
		in_pl[KIND_AMP].short.value  = {4'd0, amp};	// upper bits stay clear
	end

	// a waiting value that matches the last push is redundant
	always_comb begin
		for (int k = 0; k < 3; k++) begin
			live[k] = pend_q[k] && !(last_ok[k] && (last_pl[k] == pend_pl[k]));
		end
	end

	////////////////////////////////////////////////////////////
	// fixed priority: freq, phase, amp
	////////////////////////////////////////////////////////////

	always_comb begin
		issue = 3'b000;
		sel   = KIND_FREQ;
		if (live[KIND_FREQ]) begin
			issue[KIND_FREQ] = 1'b1;
			sel              = KIND_FREQ;
		end else if (live[KIND_PHASE]) begin
			issue[KIND_PHASE] = 1'b1;
			sel               = KIND_PHASE;
		end else if (live[KIND_AMP]) begin
			issue[KIND_AMP] = 1'b1;
			sel             = KIND_AMP;
		end
	end

	assign push         = |live;
	assign push_kind    = sel;
	assign push_payload = pend_pl[sel];

	// flags: a new strobe wins over issue or discard
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pend_q  <= 3'b000;
			last_ok <= 3'b000;		// first write of each kind always passes
		end else begin
			for (int k = 0; k < 3; k++) begin
				pend_q[k] <= strb[k] || (live[k] && !issue[k]);	// drop stale ones
				if (issue[k]) begin
					last_ok[k] <= 1'b1;
				end
			end
		end
	end

	// values
	always_ff @(posedge clk_in) begin
		for (int k = 0; k < 3; k++) begin
			if (strb[k]) begin
				pend_pl[k] <= in_pl[k];	// later strobe overwrites
			end
			if (issue[k]) begin
				last_pl[k] <= pend_pl[k];
			end
		end
	end

	// a pushed kind was waiting, and its flag is gone next cycle
	// unless a fresh strobe refilled it
	a_push_was_pending: assert property (@(posedge clk_in) disable iff (reset_in)
		push |-> pend_q[push_kind] ##1 (!pend_q[$past(push_kind)] || $past(strb[push_kind])));

endmodule

//--- design/update_fifo.sv
module update_fifo
	import update_req_pkg::*;
#(
	parameter int DEPTH = 4			// power of two, at least 2
) (
	input  logic            clk_in,
	input  logic            reset_in,
	input  logic            push,
	input  req_kind_e       push_kind,
	input  update_payload_u push_payload,
	input  logic            pop,
	output req_kind_e       head_kind,	// valid while empty is low
	output update_payload_u head_payload,
	output logic            empty,
	output logic            overflow	// sticky until reset
);

	localparam int AW = $clog2(DEPTH);

	if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_bad_depth
		$error("update_fifo DEPTH must be a power of two of at least 2");
	end

	logic [REQ_BITS-1:0] mem [DEPTH];	// request storage
	logic [AW-1:0]       wr_ptr;		// wraps by itself
	logic [AW-1:0]       rd_ptr;
	logic [AW:0]         count;		// 0 .. DEPTH
	logic                full;
	logic                do_push;
	logic                do_pop;
	logic [REQ_BITS-1:0] head_word;

	assign full    = (count == (AW + 1)'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;	// full drops the request
	assign do_pop  = pop && !empty;

	// head falls through, no read latency
	assign head_word    = mem[rd_ptr];
	assign head_kind    = req_kind_e'(head_word[REQ_BITS-1 -: 2]);
	assign head_payload = update_payload_u'(head_word[47:0]);

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
			if (push && full) begin
				overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (do_push) begin
			mem[wr_ptr] <= {push_kind, push_payload};
		end
	end

	// the writer must look at empty before it takes a word
	a_no_pop_empty: assert property (@(posedge clk_in) disable iff (reset_in)
		pop |-> !empty);

	a_count_bound: assert property (@(posedge clk_in) disable iff (reset_in)
		count <= (AW + 1)'(DEPTH));

endmodule

//--- design/dds_serial_writer.sv
module dds_serial_writer
	import dds_spi_pkg::*;
	import update_req_pkg::*;
(
	input  logic            clk_in,
	input  logic            reset_in,
	input  req_kind_e       head_kind,	// fifo head
	input  update_payload_u head_payload,
	input  logic            empty,
	output logic            pop,		// takes the head this cycle
	output logic            sclk,		// clk_in / 2 during a transfer
	output logic            csb,		// active low chip select
	output logic            sdio,		// msb first
	output logic            io_update,	// latches the new register values
	output logic            dds_reset,
	output logic            done		// one pulse per finished write
);

	localparam logic [1:0] ST_IDLE      = 2'd0;	// wait for a request
	localparam logic [1:0] ST_TX        = 2'd1;	// shift out the instruction
	localparam logic [1:0] ST_IO_UPDATE = 2'd2;	// pulse io_update
	localparam logic [1:0] ST_DONE      = 2'd3;	// pulse done

	logic [1:0]  state;
	logic        slot;			// 0: sclk low, 1: sclk high
	logic [6:0]  bits_left;		// bits still to send
	logic [63:0] shreg;			// instruction, left aligned
	logic [63:0] load_word;
	logic [6:0]  load_bits;
	logic [12:0] short_addr;
	logic [15:0] short_data;

	////////////////////////////////////////////////////////////
	// instruction build from the fifo head
	////////////////////////////////////////////////////////////

	always_comb begin
		short_addr = (head_kind == KIND_AMP) ? ADDR_AMP : ADDR_PHASE;
		if (head_kind == KIND_AMP) begin
			short_data = {6'd0, head_payload.short.value[9:0]};	// 10-bit amplitude
		end else begin
			short_data = {2'd0, head_payload.short.value};	// 14-bit phase
		end
		if (head_kind == KIND_FREQ) begin
			load_word = {INSTR_WRITE, LEN_CODE_64, ADDR_FTW, head_payload.ftw};
			load_bits = 7'(FREQ_INSTR_BITS);
		end else begin
			load_word = {INSTR_WRITE, LEN_CODE_32, short_addr, short_data, 32'd0};
			load_bits = 7'(SHORT_INSTR_BITS);
		end
	end

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	assign pop = (state == ST_IDLE) && !empty;

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state     <= ST_IDLE;
			slot      <= 1'b0;
			bits_left <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (pop) begin
						state     <= ST_TX;
						slot      <= 1'b0;
						bits_left <= load_bits;
					end
				end
				ST_TX: begin
					slot <= ~slot;
					if (slot) begin			// end of one bit slot
						bits_left <= bits_left - 1'b1;
						if (bits_left == 7'd1) begin
							state <= ST_IO_UPDATE;	// last bit sampled
						end
					end
				end
				ST_IO_UPDATE: begin
					state <= ST_DONE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// shift after the rising sclk half, so sdio moves while sclk is low
	always_ff @(posedge clk_in) begin
		if (pop) begin
			shreg <= load_word;
		end else if ((state == ST_TX) && slot) begin
			shreg <= {shreg[62:0], 1'b0};
		end
	end

	////////////////////////////////////////////////////////////
	// chip pins
	////////////////////////////////////////////////////////////

	assign csb       = (state != ST_TX);
	assign sclk      = (state == ST_TX) && slot;
	assign sdio      = (state == ST_TX) && shreg[63];	// parked low between writes
	assign io_update = (state == ST_IO_UPDATE);
	assign done      = (state == ST_DONE);
	assign dds_reset = reset_in;		// chip follows system reset

	// a transfer only starts on a word taken from the fifo
	a_csb_after_pop: assert property (@(posedge clk_in) disable iff (reset_in)
		$fell(csb) |-> $past(pop));

	// io_update alone, then done on the following cycle
	a_update_then_done: assert property (@(posedge clk_in) disable iff (reset_in)
		io_update |-> !done ##1 (done && !io_update));

endmodule

//--- design/dds_update_top.sv
module dds_update_top
	import update_req_pkg::*;
#(
	parameter int FIFO_DEPTH = 4		// pending requests held
) (
	input  logic        clk_in,
	input  logic        reset_in,
	input  logic [47:0] freq,
	input  logic [13:0] phase,
	input  logic [9:0]  amp,
	input  logic        freq_dv,
	input  logic        phase_dv,
	input  logic        amp_dv,
	output logic        sclk,
	output logic        csb,
	output logic        sdio,
	output logic        io_update,
	output logic        dds_reset,
	output logic        done,
	output logic        overflow
);

	// filter -> fifo
	logic            push;
	req_kind_e       push_kind;
	update_payload_u push_payload;

	// fifo -> writer
	req_kind_e       head_kind;
	update_payload_u head_payload;
	logic            empty;
	logic            pop;

	tuning_change_filter u_filter (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.freq         (freq),
		.phase        (phase),
		.amp          (amp),
		.freq_dv      (freq_dv),
		.phase_dv     (phase_dv),
		.amp_dv       (amp_dv),
		.push         (push),
		.push_kind    (push_kind),
		.push_payload (push_payload)
	);

	update_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.push         (push),
		.push_kind    (push_kind),
		.push_payload (push_payload),
		.pop          (pop),
		.head_kind    (head_kind),
		.head_payload (head_payload),
		.empty        (empty),
		.overflow     (overflow)
	);

	dds_serial_writer u_writer (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.head_kind    (head_kind),
		.head_payload (head_payload),
		.empty        (empty),
		.pop          (pop),
		.sclk         (sclk),
		.csb          (csb),
		.sdio         (sdio),
		.io_update    (io_update),
		.dds_reset    (dds_reset),
		.done         (done)
	);

endmodule

//--- tests/dds_serial_monitor.sv
module dds_serial_monitor (
	input  logic        sclk,
	input  logic        csb,
	input  logic        sdio,
	output logic [63:0] word,	// last finished word, right aligned
	output int          nbits,	// its length
	output int          count	// bumps once per finished word
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [63:0] shift_q;		// bits so far, newest in bit 0
	int          nbits_q;		// bits so far

	// clear on csb fall (sclk is low then), shift on rising sclk
	always @(posedge sclk or negedge csb) begin
		if (!sclk) begin
			shift_q <= '0;
			nbits_q <= 0;
		end else if (!csb) begin
			shift_q <= {shift_q[62:0], sdio};	// chip samples here
			nbits_q <= nbits_q + 1;
		end
	end

	// hand the word over when the frame closes
	always @(posedge csb) begin
		if (nbits_q != 0) begin			// skip power-up x to 1 edge
			word  <= shift_q;
			nbits <= nbits_q;
			count <= count + 1;
		end
	end

endmodule

//--- tests/tb_dds_update.sv
module tb_dds_update
	import dds_spi_pkg::*;
	import update_req_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH = 4;

	logic        clk_in = 1'b0;
	logic        reset_in;
	logic [47:0] freq;
	logic [13:0] phase;
	logic [9:0]  amp;
	logic        freq_dv, phase_dv, amp_dv;
	logic        sclk, csb, sdio, io_update, dds_reset, done, overflow;

	logic [63:0] mon_word;
	int          mon_bits;
	int          mon_count;

	// stimulus table with one entry per row in each queue
	string       row_name[$];
	logic [2:0]  row_mask[$];		// {amp, phase, freq} strobes
	logic [47:0] row_freq[$];
	logic [13:0] row_phase[$];
	logic [9:0]  row_amp[$];
	int          row_idle[$];		// 0 keeps the next row back to back

	// reference model state
	logic [63:0] exp_word_q[$];
	int          exp_bits_q[$];
	logic [47:0] last_val[3];		// last issued value per kind
	logic [2:0]  last_ok = 3'b000;
	int          burst = 0;		// requests since the last drain
	int          exp_writes = 0;
	logic        exp_ovf = 1'b0;

	int    seed;
	int    wd_limit = 0;
	int    n_checks = 0;
	int    n_errors = 0;
	int    row_errors = 0;
	int    done_cnt = 0;
	int    seen_words = 0;
	logic  last_csb = 1'b1;
	logic  last_io = 1'b0;
	string cur_name = "";

	always #4 clk_in = ~clk_in;		// 8 ns period

	dds_update_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) UUT (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.freq      (freq),
		.phase     (phase),
		.amp       (amp),
		.freq_dv   (freq_dv),
		.phase_dv  (phase_dv),
		.amp_dv    (amp_dv),
		.sclk      (sclk),
		.csb       (csb),
		.sdio      (sdio),
		.io_update (io_update),
		.dds_reset (dds_reset),
		.done      (done),
		.overflow  (overflow)
	);

	dds_serial_monitor mon (
		.sclk  (sclk),
		.csb   (csb),
		.sdio  (sdio),
		.word  (mon_word),
		.nbits (mon_bits),
		.count (mon_count)
	);

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		n_checks++;
		if (actual !== expected) begin
			$display("Fail %s %s: expected %h, actual %h", cur_name, what, expected, actual);
			n_errors++;
			row_errors++;
		end
	endtask

	// right aligned serial word as the chip expects it
	function automatic logic [63:0] expected_word(input req_kind_e kind,
			input logic [47:0] value);
		case (kind)
			KIND_FREQ:  return {INSTR_WRITE, LEN_CODE_64, ADDR_FTW, value};
			KIND_PHASE: return {32'd0, INSTR_WRITE, LEN_CODE_32, ADDR_PHASE, 2'd0, value[13:0]};
			default:    return {32'd0, INSTR_WRITE, LEN_CODE_32, ADDR_AMP, 6'd0, value[9:0]};
		endcase
	endfunction

	// outputs are stable at the falling edge
	task automatic sample_outputs();
		logic csb_rose;
		csb_rose = csb && !last_csb;
		if (!reset_in) begin
			if (mon_count != seen_words) begin
				seen_words = mon_count;
				if (exp_word_q.size() == 0) begin
					$display("Error in %s: a %0d-bit serial write came out with none expected",
						cur_name, mon_bits);
					n_errors++;
					row_errors++;
				end else begin
					check_value("serial word", exp_word_q.pop_front(), mon_word);
					check_value("bit count", 64'(exp_bits_q.pop_front()), 64'(mon_bits));
				end
			end
			if (csb_rose || io_update) begin
				check_value("io_update after csb rise", 64'(csb_rose), 64'(io_update));
			end
			if (last_io || done) begin
				check_value("done after io_update", 64'(last_io), 64'(done));
			end
			if (done) begin
				done_cnt++;
			end
		end
		last_csb = csb;
		last_io  = io_update;
	endtask

	task automatic step();
		@(negedge clk_in);
		sample_outputs();		// drive only after this
	endtask

	////////////////////////////////////////////////////////////
	// table and model
	////////////////////////////////////////////////////////////

	function automatic logic [47:0] rand_ftw();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[47:0];
	endfunction

	task automatic add_row(input string name, input logic [2:0] mask, input logic [47:0] f,
			input logic [13:0] p, input logic [9:0] a, input int idle);
		row_name.push_back(name);
		row_mask.push_back(mask);
		row_freq.push_back(f);
		row_phase.push_back(p);
		row_amp.push_back(a);
		row_idle.push_back(idle);
	endtask

	task automatic build_table();
		logic [47:0] f_all;
		f_all = rand_ftw();
		add_row("freq_single", 3'b001, rand_ftw(), 14'd0, 10'd0, 8);
		add_row("phase_single", 3'b010, 48'd0, 14'h2a5c, 10'd0, 8);
		add_row("amp_zero_first", 3'b100, 48'd0, 14'd0, 10'd0, 8);	// zero still goes out
		add_row("all_three", 3'b111, f_all, 14'h1234, 10'h155, 8);
		add_row("repeat_freq", 3'b001, f_all, 14'd0, 10'd0, 140);	// long enough to see a stray write
		add_row("repeat_all", 3'b111, f_all, 14'h1234, 10'h155, 140);
		add_row("phase_change", 3'b010, 48'd0, 14'h0001, 10'd0, 8);
		add_row("amp_change", 3'b100, 48'd0, 14'd0, 10'h3c7, 8);
		for (int i = 0; i < 7; i++) begin	// more than depth + 1 in flight
			add_row($sformatf("burst_%0d", i), 3'b001, rand_ftw(), 14'd0, 10'd0,
				(i == 6) ? 8 : 0);
		end
	endtask

	function automatic logic [47:0] row_value(input int r, input req_kind_e kind);
		case (kind)
			KIND_FREQ:  return row_freq[r];
			KIND_PHASE: return 48'(row_phase[r]);
			default:    return 48'(row_amp[r]);
		endcase
	endfunction

	// freq goes before phase before amp and repeats of the last issued value vanish
	task automatic model_row(input int r);
		logic [47:0] value;
		req_kind_e   kind;
		for (int k = 0; k < 3; k++) begin
			kind  = req_kind_e'(k);
			value = row_value(r, kind);
			if (row_mask[r][k] && !(last_ok[k] && (last_val[k] == value))) begin
				last_ok[k]  = 1'b1;		// issued even when the fifo drops it
				last_val[k] = value;
				if (burst < FIFO_DEPTH + 1) begin	// fifo plus the word in flight
					exp_word_q.push_back(expected_word(kind, value));
					exp_bits_q.push_back((kind == KIND_FREQ) ? int'(FREQ_INSTR_BITS) :
						int'(SHORT_INSTR_BITS));
					burst++;
					exp_writes++;
				end else begin
					exp_ovf = 1'b1;
				end
			end
		end
	endtask

	function automatic int watchdog_cycles();
		int total;
		total = 200;
		for (int r = 0; r < row_name.size(); r++) begin
			total += $countones(row_mask[r]) * 70 + row_idle[r];
		end
		return total;
	endfunction

	task automatic report_row();
		if (row_errors == 0) begin
			$display("%s: ok", cur_name);
		end else begin
			$display("%s: %0d error(s)", cur_name, row_errors);
		end
	endtask

	////////////////////////////////////////////////////////////
	// sequences
	////////////////////////////////////////////////////////////

	task automatic reset_test();
		cur_name   = "reset";
		row_errors = 0;
		repeat (10) begin
			step();
			check_value("csb in reset", 64'd1, 64'(csb));
			check_value("io_update in reset", 64'd0, 64'(io_update));
			check_value("done in reset", 64'd0, 64'(done));
			check_value("dds_reset in reset", 64'd1, 64'(dds_reset));
		end
		reset_in = 1'b0;
		step();
		check_value("csb after reset", 64'd1, 64'(csb));
		check_value("sclk after reset", 64'd0, 64'(sclk));
		check_value("io_update after reset", 64'd0, 64'(io_update));
		check_value("done after reset", 64'd0, 64'(done));
		check_value("dds_reset after reset", 64'd0, 64'(dds_reset));
		check_value("overflow after reset", 64'd0, 64'(overflow));
		report_row();
	endtask

	initial begin
		reset_in = 1'b1;
		freq     = '0;
		phase    = '0;
		amp      = '0;
		freq_dv  = 1'b0;
		phase_dv = 1'b0;
		amp_dv   = 1'b0;
		seed     = 78443;
		build_table();
		wd_limit = watchdog_cycles();
		reset_test();
		for (int r = 0; r < row_name.size(); r++) begin
			cur_name   = row_name[r];
			row_errors = 0;
			step();
			freq  = row_freq[r];
			phase = row_phase[r];
			amp   = row_amp[r];
			{amp_dv, phase_dv, freq_dv} = row_mask[r];
			model_row(r);
			if (row_idle[r] > 0) begin
				step();
				{amp_dv, phase_dv, freq_dv} = 3'b000;
				while (done_cnt < exp_writes) begin	// until every expected write is done
					step();
				end
				repeat (row_idle[r]) begin
					step();
				end
				check_value("done count", 64'(exp_writes), 64'(done_cnt));
				check_value("words missing", 64'd0, 64'(exp_word_q.size()));
				check_value("overflow", 64'(exp_ovf), 64'(overflow));
				burst = 0;			// fifo and writer drained
			end
			report_row();
		end
		$display("tests %0d, checks %0d, errors %0d, writes %0d",
			row_name.size() + 1, n_checks, n_errors, done_cnt);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (wd_limit > 0);
		repeat (wd_limit) @(posedge clk_in);
		$display("Error: watchdog expired after %0d cycles in %s, the run did not finish",
			wd_limit, cur_name);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- filelist.f
design/dds_spi_pkg.sv
design/update_req_pkg.sv
design/tuning_change_filter.sv
design/update_fifo.sv
design/dds_serial_writer.sv
design/dds_update_top.sv
tests/dds_serial_monitor.sv
tests/tb_dds_update.sv

//--- Makefile
SIM := obj_dir/Vtb_dds_update

.PHONY: run clean

$(SIM): filelist.f $(wildcard design/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_dds_update -f filelist.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	test $$status -eq 0 && ! grep -qF '*** FAILED ***' sim.log

clean:
	rm -rf obj_dir sim.log
